//--- verification/isp_vectors.txt
// seed mode ratio p0 p1 p2 p3 expected, all hex
// exposure: p0-p2 red, green, blue fill; focus: p0 window gray, p1-p3 outer, middle, inner step
9a4b6286 1 2 80 80 80 00 80
13572468 0 1 30 00 04 08 00
0badf00d 1 0 f0 60 30 00 1e
2468ace0 0 3 30 00 08 00 01
55aa33cc 1 1 40 c0 a0 00 4c
7e57c0de 0 2 30 03 03 03 02
c001d00d 1 3 c0 90 f0 00 fd
31415926 0 0 30 03 06 00 01
27182818 1 3 20 50 70 00 98
0ddba11a 0 1 30 0a 00 00 02
600dcafe 0 3 28 00 00 14 00

//--- vlog.f
rtl/isp_pkg.sv
rtl/isp_beat_scaler.sv
rtl/isp_focus_window.sv
rtl/isp_focus_contrast.sv
rtl/isp_exposure_acc.sv
rtl/isp_top.sv
verification/isp_properties.sv
verification/isp_checker.sv
verification/isp_tb.sv

//--- verification/isp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module isp_tb;
    import isp_pkg::*;

    localparam int          MAX_PICS       = 16;
    localparam int          FIELDS         = 8;
    localparam int          CYCLES_PER_PIC = 600;
    localparam logic [31:0] LCG_SEED       = 32'h9a4b_6286;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_mode;
    ratio_t      in_ratio_mode;
    logic        pix_valid;
    beat_t       pix_data;
    logic        busy;
    logic        out_valid;
    result_t     out_data;
    logic        exp_push;
    result_t     exp_value;
    int          errors;
    int          results;

    logic [31:0] vec [FIELDS * MAX_PICS];
    int          n_pics;
    logic        vectors_loaded;
    logic [31:0] rand_state;
    logic [31:0] gap_state;
    logic        cur_mode;
    ratio_t      cur_ratio;
    int          cur_par [4];
    int          fail_total;

    isp_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_mode       (in_mode),
        .in_ratio_mode (in_ratio_mode),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .busy          (busy),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    isp_checker i_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pix_valid (pix_valid),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .exp_push  (exp_push),
        .exp_value (exp_value),
        .errors    (errors),
        .results   (results)
    );

    bind isp_top isp_properties i_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 outer ring, 1 middle ring, 2 inner 2x2
    function automatic int ring_of(input int r, input int c);
        int m;
        m = (r < c) ? r : c;
        m = (WIN_SIZE - 1 - r < m) ? WIN_SIZE - 1 - r : m;
        m = (WIN_SIZE - 1 - c < m) ? WIN_SIZE - 1 - c : m;
        return m;
    endfunction

    // ------------------------------
    // picture generation
    // ------------------------------
    task automatic build_beat(input int b, output beat_t data);
        int plane, row, col, wr, wc, s, amp;
        for (int i = 0; i < PIX_PER_BEAT; i++) begin
            rand_state = lcg_next(rand_state);
            plane = b / PLANE_BEATS;
            row   = (b % PLANE_BEATS) / 2;
            col   = (b % 2) * PIX_PER_BEAT + i;
            wr    = row - WIN_FIRST_ROW;
            wc    = col - WIN_FIRST_COL;
            if (cur_mode) begin
                // noise only in the bits that ratio and weight shift out
                s = 2 - int'(cur_ratio) + ((plane == 1) ? 1 : 2);
                data[8*i +: 8] = pixel_t'(cur_par[plane])
                                 | (rand_state[31:24] & pixel_t'((1 << s) - 1));
            end else if (wr >= 0 && wr < WIN_SIZE && wc >= 0 && wc < WIN_SIZE) begin
                amp = cur_par[1 + ring_of(wr, wc)];
                if (plane == 1) begin
                    data[8*i +: 8] = pixel_t'(2 * (cur_par[0] + amp * ((wr + wc) % 2)));
                end else begin
                    data[8*i +: 8] = {6'd0, rand_state[25:24]};
                end
            end else begin
                data[8*i +: 8] = rand_state[31:24];
            end
        end
    endtask

    task automatic send_picture(input int n);
        beat_t data;
        rand_state = vec[FIELDS * n];
        cur_mode   = vec[FIELDS * n + 1][0];
        cur_ratio  = vec[FIELDS * n + 2][1:0];
        for (int k = 0; k < 4; k++) begin
            cur_par[k] = vec[FIELDS * n + 3 + k][7:0];
        end
        in_valid      <= 1'b1;
        in_mode       <= cur_mode;
        in_ratio_mode <= cur_ratio;
        exp_push      <= 1'b1;
        exp_value     <= vec[FIELDS * n + 7][7:0];
        @(posedge clk);
        in_valid <= 1'b0;
        exp_push <= 1'b0;
        for (int b = 0; b < BEATS_PER_PIC; b++) begin
            gap_state = lcg_next(gap_state);
            if (gap_state[31]) begin
                pix_valid <= 1'b0;
                @(posedge clk);
            end
            build_beat(b, data);
            pix_valid <= 1'b1;
            pix_data  <= data;
            @(posedge clk);
        end
        pix_valid <= 1'b0;
        // value read after the edge belongs to the cycle just ended
        @(posedge clk);
        while (!out_valid) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : main
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_mode        = 1'b0;
        in_ratio_mode  = '0;
        pix_valid      = 1'b0;
        pix_data       = '0;
        exp_push       = 1'b0;
        exp_value      = '0;
        gap_state      = LCG_SEED;
        vectors_loaded = 1'b0;
        $readmemh("verification/isp_vectors.txt", vec);
        n_pics = 0;
        while (n_pics < MAX_PICS && !$isunknown(vec[FIELDS * n_pics])) begin
            n_pics++;
        end
        vectors_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < n_pics; n++) begin
            send_picture(n);
        end
        repeat (4) @(posedge clk);
        fail_total = errors + i_dut.i_props.failures;
        if (n_pics == 0) begin
            $display("no stimulus vectors were read");
        end
        if (results != n_pics) begin
            $display("expected %0d results but saw %0d", n_pics, results);
        end
        $display("pictures %0d, results %0d, check errors %0d, assertion failures %0d",
                 n_pics, results, errors, i_dut.i_props.failures);
        if (fail_total == 0 && results == n_pics && n_pics > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (vectors_loaded);
        repeat ((n_pics + 1) * CYCLES_PER_PIC) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles",
                 (n_pics + 1) * CYCLES_PER_PIC);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/isp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module isp_checker (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             pix_valid,
    input  logic             busy,
    input  logic             out_valid,
    input  isp_pkg::result_t out_data,
    input  logic             exp_push,
    input  isp_pkg::result_t exp_value,
    output int               errors,
    output int               results
);
    import isp_pkg::*;

    result_t pending [$];
    result_t expected;
    int      beats;
    int      since_last;
    logic    armed;
    logic    started;

    initial begin
        errors  = 0;
        results = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            beats      = 0;
            since_last = 0;
            armed      = 1'b0;
            started    = 1'b0;
        end else begin
            if (!started && (busy || out_valid)) begin
                $display("ERROR at %0t: busy or out_valid high after reset with no request",
                         $time);
                errors++;
            end
            if (exp_push) begin
                pending.push_back(exp_value);
            end
            if (in_valid) begin
                started = 1'b1;
                beats   = 0;
                armed   = 1'b0;
            end
            if (armed) begin
                since_last++;
            end
            // latency counts from the edge that takes the last beat
            if (pix_valid) begin
                beats++;
                if (beats == BEATS_PER_PIC) begin
                    armed      = 1'b1;
                    since_last = 0;
                end
            end
            if (out_valid) begin
                results++;
                if (pending.size() == 0) begin
                    $display("ERROR at %0t: out_valid with no picture pending", $time);
                    errors++;
                end else begin
                    expected = pending.pop_front();
                    if (out_data !== expected) begin
                        $display("CHECK FAILED at %0t: out_data = %0d, expected %0d",
                                 $time, out_data, expected);
                        errors++;
                    end
                end
                if (!armed) begin
                    $display("ERROR at %0t: out_valid before the last beat arrived", $time);
                    errors++;
                end else if (since_last != RESULT_LATENCY) begin
                    $display("CHECK FAILED at %0t: out_valid latency = %0d, expected %0d",
                             $time, since_last, RESULT_LATENCY);
                    errors++;
                end
                armed = 1'b0;
            end else begin
                if (out_data !== '0) begin
                    $display("CHECK FAILED at %0t: out_data = %0d, expected 0 while idle",
                             $time, out_data);
                    errors++;
                end
                if (armed && since_last >= RESULT_LATENCY) begin
                    $display("ERROR at %0t: no out_valid %0d cycles after the last beat",
                             $time, RESULT_LATENCY);
                    errors++;
                    armed = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/isp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module isp_properties (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             mode,
    input  logic             busy,
    input  logic             out_valid,
    input  isp_pkg::result_t out_data
);
    int failures = 0;

    // ------------------------------
    // busy framing
    // ------------------------------
    busy_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> busy)
        else begin
            $error("busy did not rise after in_valid");
            failures++;
        end

    busy_ends_with_result: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(out_valid))
        else begin
            $error("busy fell without out_valid");
            failures++;
        end

    result_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else begin
            $error("out_valid while busy is low");
            failures++;
        end

    // ------------------------------
    // output pulse
    // ------------------------------
    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid longer than one cycle");
            failures++;
        end

    idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else begin
            $error("out_data not zero while out_valid is low");
            failures++;
        end

    // focus decision is one of three codes
    focus_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !mode |-> out_data <= 8'd2)
        else begin
            $error("focus result above 2");
            failures++;
        end

endmodule

`default_nettype wire

//--- rtl/isp_top.sv
`timescale 1ns/1ps
`default_nettype none

module isp_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             in_mode,
    input  isp_pkg::ratio_t  in_ratio_mode,
    input  logic             pix_valid,
    input  isp_pkg::beat_t   pix_data,
    output logic             busy,
    output logic             out_valid,
    output isp_pkg::result_t out_data
);
    import isp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT
    } state_t;

    state_t     state;
    logic [4:0] lat_cnt;
    logic       lat_end;
    logic       fire;

    logic       mode;
    logic       px_valid;
    beat_t      px_data;
    beat_idx_t  px_idx;
    logic       last_beat;

    logic       line_valid;
    logic [3:0] line_idx;
    pixel_t     line_p0, line_p1, line_p2, line_p3, line_p4, line_p5;

    logic       focus_done;
    result_t    focus_result;
    result_t    expo_result;
    result_t    sel_result;

    isp_beat_scaler i_scaler (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_mode       (in_mode),
        .in_ratio_mode (in_ratio_mode),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .mode          (mode),
        .px_valid      (px_valid),
        .px_data       (px_data),
        .px_idx        (px_idx),
        .last_beat     (last_beat)
    );

    isp_focus_window i_window (
        .clk        (clk),
        .rst_n      (rst_n),
        .px_valid   (px_valid),
        .px_data    (px_data),
        .px_idx     (px_idx),
        .last_beat  (last_beat),
        .line_valid (line_valid),
        .line_idx   (line_idx),
        .line_p0    (line_p0),
        .line_p1    (line_p1),
        .line_p2    (line_p2),
        .line_p3    (line_p3),
        .line_p4    (line_p4),
        .line_p5    (line_p5)
    );

    isp_focus_contrast i_contrast (
        .clk          (clk),
        .rst_n        (rst_n),
        .line_valid   (line_valid),
        .line_idx     (line_idx),
        .line_p0      (line_p0),
        .line_p1      (line_p1),
        .line_p2      (line_p2),
        .line_p3      (line_p3),
        .line_p4      (line_p4),
        .line_p5      (line_p5),
        .focus_done   (focus_done),
        .focus_result (focus_result)
    );

    isp_exposure_acc i_expo (
        .clk         (clk),
        .rst_n       (rst_n),
        .px_valid    (px_valid),
        .px_data     (px_data),
        .last_beat   (last_beat),
        .expo_result (expo_result)
    );

    // ------------------------------
    // sequencing
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    // last_beat trails the input beat by one, so count from 2
                    if (last_beat) begin
                        state   <= ST_WAIT;
                        lat_cnt <= 5'd2;
                    end
                end
                ST_WAIT: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (out_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy       = (state != ST_IDLE);
    assign lat_end    = (state == ST_WAIT) && (lat_cnt == 5'(RESULT_LATENCY - 1));
    // focus sums close on the same cycle as the count
    assign fire       = lat_end && (mode || focus_done);
    assign sel_result = mode ? expo_result : focus_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= fire;
            out_data  <= fire ? sel_result : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/isp_exposure_acc.sv
`timescale 1ns/1ps
`default_nettype none

module isp_exposure_acc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             px_valid,
    input  isp_pkg::beat_t   px_data,
    input  logic             last_beat,
    output isp_pkg::result_t expo_result
);
    import isp_pkg::*;

    logic [9:0]  grp_d [PIX_PER_BEAT / 4];
    logic [9:0]  grp_q [PIX_PER_BEAT / 4];
    logic        s1_valid;
    logic        s1_last;
    logic        first;
    logic [11:0] beat_sum;
    logic [17:0] acc;
    logic [17:0] acc_next;

    // first stage, groups of four bytes
    always_comb begin
        for (int g = 0; g < PIX_PER_BEAT / 4; g++) begin
            grp_d[g] = '0;
            for (int k = 0; k < 4; k++) begin
                grp_d[g] = grp_d[g] + 10'(px_data[8 * (4 * g + k) +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (px_valid) begin
            grp_q <= grp_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            first    <= 1'b1;
        end else begin
            s1_valid <= px_valid;
            s1_last  <= last_beat;
            if (s1_valid) begin
                first <= s1_last;
            end
        end
    end

    // second stage straight into the accumulator
    assign beat_sum = 12'(grp_q[0]) + 12'(grp_q[1]) + 12'(grp_q[2]) + 12'(grp_q[3]);
    assign acc_next = (first ? 18'd0 : acc) + 18'(beat_sum);

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc <= acc_next;
        end
        if (s1_valid && s1_last) begin
            expo_result <= acc_next[EXPO_SHIFT +: 8];
        end
    end

endmodule

`default_nettype wire

//--- rtl/isp_focus_contrast.sv
`timescale 1ns/1ps
`default_nettype none

module isp_focus_contrast (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             line_valid,
    input  logic [3:0]       line_idx,
    input  isp_pkg::pixel_t  line_p0,
    input  isp_pkg::pixel_t  line_p1,
    input  isp_pkg::pixel_t  line_p2,
    input  isp_pkg::pixel_t  line_p3,
    input  isp_pkg::pixel_t  line_p4,
    input  isp_pkg::pixel_t  line_p5,
    output logic             focus_done,
    output isp_pkg::result_t focus_result
);
    import isp_pkg::*;

    pixel_t     p [WIN_SIZE];
    pixel_t     d [WIN_SIZE - 1];
    logic       d_valid;
    logic [3:0] d_idx;
    logic [2:0] d_pos;
    logic       inner4;
    logic       inner2;
    diff_sum_t  add6, add4, add2;
    diff_sum_t  sum6, sum4, sum2;
    diff_sum_t  q6, q4, q2;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign p[0] = line_p0;
    assign p[1] = line_p1;
    assign p[2] = line_p2;
    assign p[3] = line_p3;
    assign p[4] = line_p4;
    assign p[5] = line_p5;

    // ------------------------------
    // neighbour differences
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            d_idx   <= '0;
        end else begin
            d_valid <= line_valid;
            d_idx   <= line_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (line_valid) begin
            for (int k = 0; k < WIN_SIZE - 1; k++) begin
                d[k] <= abs_diff(p[k], p[k + 1]);
            end
        end
    end

    // position of the line within its orientation
    assign d_pos  = (d_idx < 4'(WIN_SIZE)) ? d_idx[2:0] : 3'(d_idx - 4'(WIN_SIZE));
    assign inner4 = (d_pos >= 3'd1) && (d_pos <= 3'(WIN_SIZE - 2));
    assign inner2 = (d_pos == 3'(WIN_SIZE / 2 - 1)) || (d_pos == 3'(WIN_SIZE / 2));

    always_comb begin
        add6 = '0;
        add4 = '0;
        for (int k = 0; k < WIN_SIZE - 1; k++) begin
            add6 = add6 + diff_sum_t'(d[k]);
            if (inner4 && k >= 1 && k <= WIN_SIZE - 3) begin
                add4 = add4 + diff_sum_t'(d[k]);
            end
        end
        add2 = inner2 ? diff_sum_t'(d[WIN_SIZE / 2 - 1]) : '0;
    end

    // ------------------------------
    // window sums
    // ------------------------------
    always_ff @(posedge clk) begin
        if (d_valid) begin
            if (d_idx == '0) begin
                sum6 <= add6;
                sum4 <= add4;
                sum2 <= add2;
            end else begin
                sum6 <= sum6 + add6;
                sum4 <= sum4 + add4;
                sum2 <= sum2 + add2;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            focus_done <= 1'b0;
        end else begin
            focus_done <= d_valid && (d_idx == 4'(2 * WIN_SIZE - 1));
        end
    end

    // mean contrast per window size
    assign q6 = sum6 / diff_sum_t'(WIN_SIZE * WIN_SIZE);
    assign q4 = sum4 / diff_sum_t'((WIN_SIZE - 2) * (WIN_SIZE - 2));
    assign q2 = sum2 / diff_sum_t'((WIN_SIZE - 4) * (WIN_SIZE - 4));

    always_comb begin
        if (q2 >= q4 && q2 >= q6) begin
            focus_result = 8'd0;
        end else if (q4 >= q6) begin
            focus_result = 8'd1;
        end else begin
            focus_result = 8'd2;
        end
    end

endmodule

`default_nettype wire

//--- rtl/isp_focus_window.sv
`timescale 1ns/1ps
`default_nettype none

module isp_focus_window (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               px_valid,
    input  isp_pkg::beat_t     px_data,
    input  isp_pkg::beat_idx_t px_idx,
    input  logic               last_beat,
    output logic               line_valid,
    output logic [3:0]         line_idx,
    output isp_pkg::pixel_t    line_p0,
    output isp_pkg::pixel_t    line_p1,
    output isp_pkg::pixel_t    line_p2,
    output isp_pkg::pixel_t    line_p3,
    output isp_pkg::pixel_t    line_p4,
    output isp_pkg::pixel_t    line_p5
);
    import isp_pkg::*;

    pixel_t     win [WIN_SIZE][WIN_SIZE];
    logic [4:0] row;
    logic       row_hit;
    logic [2:0] wr_row;
    logic [2:0] rd_sel;
    pixel_t     line_px [WIN_SIZE];

    // ------------------------------
    // gray accumulation
    // ------------------------------
    // two beats per row within a plane
    assign row     = 5'((px_idx % PLANE_BEATS) >> 1);
    assign row_hit = (row >= WIN_FIRST_ROW) && (row < WIN_FIRST_ROW + WIN_SIZE);
    assign wr_row  = 3'(row - 5'(WIN_FIRST_ROW));

    always_ff @(posedge clk) begin
        if (px_valid && px_idx == '0) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                for (int c = 0; c < WIN_SIZE; c++) begin
                    win[r][c] <= '0;
                end
            end
        end else if (px_valid && row_hit) begin
            // even beat holds the left half, odd beat the right half
            for (int c = 0; c < WIN_SIZE; c++) begin
                if ((WIN_FIRST_COL + c) / PIX_PER_BEAT == int'(px_idx[0])) begin
                    win[wr_row][c] <= win[wr_row][c]
                                      + px_data[8 * ((WIN_FIRST_COL + c) % PIX_PER_BEAT) +: 8];
                end
            end
        end
    end

    // ------------------------------
    // replay, rows then columns
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= 1'b0;
            line_idx   <= '0;
        end else if (last_beat) begin
            line_valid <= 1'b1;
            line_idx   <= '0;
        end else if (line_valid) begin
            if (line_idx == 4'(2 * WIN_SIZE - 1)) begin
                line_valid <= 1'b0;
            end else begin
                line_idx <= line_idx + 1'b1;
            end
        end
    end

    assign rd_sel = (line_idx < 4'(WIN_SIZE)) ? line_idx[2:0] : 3'(line_idx - 4'(WIN_SIZE));

    always_comb begin
        for (int k = 0; k < WIN_SIZE; k++) begin
            line_px[k] = (line_idx < 4'(WIN_SIZE)) ? win[rd_sel][k] : win[k][rd_sel];
        end
    end

    assign line_p0 = line_px[0];
    assign line_p1 = line_px[1];
    assign line_p2 = line_px[2];
    assign line_p3 = line_px[3];
    assign line_p4 = line_px[4];
    assign line_p5 = line_px[5];

endmodule

`default_nettype wire

//--- rtl/isp_beat_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module isp_beat_scaler (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_mode,
    input  isp_pkg::ratio_t    in_ratio_mode,
    input  logic               pix_valid,
    input  isp_pkg::beat_t     pix_data,
    output logic               mode,
    output logic               px_valid,
    output isp_pkg::beat_t     px_data,
    output isp_pkg::beat_idx_t px_idx,
    output logic               last_beat
);
    import isp_pkg::*;

    ratio_t    ratio_q;
    beat_idx_t beat_cnt;
    logic      green;
    pixel_t    adj;
    beat_t     weighted;

    function automatic pixel_t adjust(input pixel_t p, input ratio_t r);
        case (r)
            2'd0:    return p >> 2;
            2'd1:    return p >> 1;
            2'd3:    return p[7] ? 8'hff : {p[6:0], 1'b0};
            default: return p;
        endcase
    endfunction

    // request capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode    <= 1'b0;
            ratio_q <= '0;
        end else if (in_valid) begin
            mode    <= in_mode;
            ratio_q <= in_ratio_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (in_valid) begin
            beat_cnt <= '0;
        end else if (pix_valid) begin
            if (beat_cnt == beat_idx_t'(BEATS_PER_PIC - 1)) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // green plane weighs twice as much as red and blue
    assign green = (beat_cnt >= beat_idx_t'(PLANE_BEATS)) &&
                   (beat_cnt < beat_idx_t'(2 * PLANE_BEATS));

    always_comb begin
        for (int i = 0; i < PIX_PER_BEAT; i++) begin
            adj = mode ? adjust(pix_data[8*i +: 8], ratio_q) : pix_data[8*i +: 8];
            weighted[8*i +: 8] = green ? (adj >> 1) : (adj >> 2);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px_valid  <= 1'b0;
            last_beat <= 1'b0;
        end else begin
            px_valid  <= pix_valid;
            last_beat <= pix_valid && (beat_cnt == beat_idx_t'(BEATS_PER_PIC - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            px_data <= weighted;
            px_idx  <= beat_cnt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/isp_pkg.sv
`default_nettype none

package isp_pkg;

    // ------------------------------
    // picture geometry
    // ------------------------------
    localparam int BEATS_PER_PIC  = 192;
    localparam int PIX_PER_BEAT   = 16;
    localparam int PLANE_BEATS    = 64;

    // centre focus window
    localparam int WIN_SIZE       = 6;
    localparam int WIN_FIRST_ROW  = 13;
    localparam int WIN_FIRST_COL  = 13;

    // sum of 1024 weighted bytes per mean step
    localparam int EXPO_SHIFT     = 10;

    // last input beat to out_valid
    localparam int RESULT_LATENCY = 16;

    // ------------------------------
    // data types
    // ------------------------------
    typedef logic [7:0]   pixel_t;
    typedef logic [127:0] beat_t;
    typedef logic [7:0]   beat_idx_t;
    typedef logic [1:0]   ratio_t;
    typedef logic [7:0]   result_t;

    // wide enough for 60 differences of up to 253
    typedef logic [13:0]  diff_sum_t;

endpackage

`default_nettype wire
